// ==== sim.f ====
+incdir+dv
logic/soc_map_pkg.sv
logic/bus_pkg.sv
logic/bus_access_fsm.sv
logic/machine_timer.sv
logic/scratch_ram.sv
logic/plic_regs.sv
logic/soc_bus_top.sv
dv/soc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module soc_bus_tb \
    -Mdir obj_dir -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/soc_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== dv/soc_bus_model.svh ====
`ifndef SOC_BUS_MODEL_SVH
`define SOC_BUS_MODEL_SVH

logic [31:0] lfsr_state = 32'hf682;
logic [7:0]  ram_shadow [soc_map_pkg::RAM_WORDS*4];
int          data_errors    = 0;
int          flag_errors    = 0;
int          claim_errors   = 0;
int          latency_errors = 0;

// galois form with one output bit per step
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return bits;
endfunction

// initial RAM contents hashed from the byte address
function automatic logic [31:0] fill_word(input int w);
    logic [31:0] a;
    a = soc_map_pkg::RAM_BASE[31:0] + 32'(4 * w);
    return a ^ (a * 32'h9e37_79b9);
endfunction

function automatic int access_bytes(input bus_pkg::ls_type_t t);
    case (t)
        bus_pkg::LS_B, bus_pkg::LS_BU: return 1;
        bus_pkg::LS_H, bus_pkg::LS_HU: return 2;
        bus_pkg::LS_D:                 return 8;
        default:                       return 4;
    endcase
endfunction

function automatic void ref_store(input int off, input bus_pkg::ls_type_t t,
                                  input logic [63:0] data);
    for (int i = 0; i < access_bytes(t); i++)
        ram_shadow[off + i] = data[8*i +: 8];
endfunction

// little endian gather, then extension by load type
function automatic logic [63:0] ref_load(input int off, input bus_pkg::ls_type_t t);
    logic [63:0] raw;
    raw = '0;
    for (int i = 0; i < access_bytes(t); i++)
        raw[8*i +: 8] = ram_shadow[off + i];
    case (t)
        bus_pkg::LS_B: return {{56{raw[7]}}, raw[7:0]};
        bus_pkg::LS_H: return {{48{raw[15]}}, raw[15:0]};
        bus_pkg::LS_W: return {{32{raw[31]}}, raw[31:0]};
        default:       return raw;
    endcase
endfunction

function automatic int ref_claim(input logic pend, input logic en);
    return (pend && en) ? soc_map_pkg::EXT_IRQ_ID : 0;
endfunction

// strobe edge to done edge
function automatic int ref_latency(input logic [63:0] addr, input bus_pkg::ls_type_t t,
                                   input logic wr);
    logic ram;
    ram = addr >= soc_map_pkg::RAM_BASE &&
          addr < soc_map_pkg::RAM_BASE + 64'(soc_map_pkg::RAM_WORDS * 4);
    if (!ram)
        return 2;
    if (wr)
        return (t == bus_pkg::LS_D) ? 3 : 2;
    return (t == bus_pkg::LS_D) ? 4 : 3;
endfunction

task automatic check_data(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
        data_errors++;
        $display("Fail %0t: %s read %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        flag_errors++;
        $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_claim(input logic [63:0] got, input int exp_id, input string what);
    if (got !== 64'(exp_id)) begin
        claim_errors++;
        $display("Fail %0t: %s returned id %0d, expected %0d", $time, what, got, exp_id);
    end
endtask

task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
        latency_errors++;
        $display("Fail %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
endtask

`endif

// ==== dv/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb;

    localparam int FILL_WORDS    = soc_map_pkg::RAM_WORDS;
    localparam int RAND_STORES   = 200;
    localparam int MISC_ACCESSES = 60;
    localparam int WAIT_CYCLES   = 40;
    // ld latency plus the idle cycle before each strobe and the done sample
    localparam int WORST_ACCESS  = 6;
    localparam int TIMEOUT_CYCLES =
        2 * ((2 * FILL_WORDS + 2 * RAND_STORES + MISC_ACCESSES) * WORST_ACCESS + WAIT_CYCLES);

    `include "soc_bus_model.svh"

    logic              clock_slow;
    logic              KEY0;
    bus_pkg::bus_req_t bus_req;
    logic              ext_irq;
    logic [63:0]       bus_read_data;
    logic              bus_read_done;
    logic              bus_write_done;
    logic              mtip;
    logic              meip;
    logic              seip;

    logic [63:0]       exp_value_q [$];
    bit                exp_claim_q [$];
    string             exp_what_q [$];
    logic              read_done_prev;
    logic              model_pending;
    logic              model_enable [2];
    int                cycle_count;
    int                off;
    bus_pkg::ls_type_t ls;
    logic [63:0]       data;
    logic [63:0]       mtime_first;
    logic [63:0]       mtime_second;

    soc_bus_top soc_bus_top_inst (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .ext_irq        (ext_irq),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .mtip           (mtip),
        .meip           (meip),
        .seip           (seip)
    );

    always #2 clock_slow = ~clock_slow;

    // one-cycle strobe, then wait for the matching done flag
    task automatic issue(input logic [63:0] addr, input bus_pkg::ls_type_t t,
                         input logic [63:0] wdata, input logic wr, output logic [63:0] rdata);
        int cycles;
        @(negedge clock_slow);
        bus_req.address    = addr;
        bus_req.write_data = wdata;
        bus_req.ls_type    = t;
        bus_req.read_en    = !wr;
        bus_req.write_en   = wr;
        @(negedge clock_slow);
        bus_req.read_en  = 1'b0;
        bus_req.write_en = 1'b0;
        cycles = 1;
        while (!(wr ? bus_write_done : bus_read_done)) begin
            @(negedge clock_slow);
            cycles++;
        end
        rdata = bus_read_data;
        check_latency(cycles - 1, ref_latency(addr, t, wr), wr ? "write" : "read");
    endtask

    task automatic bus_write(input logic [63:0] addr, input bus_pkg::ls_type_t t,
                             input logic [63:0] wdata);
        logic [63:0] unused;
        issue(addr, t, wdata, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [63:0] addr, input bus_pkg::ls_type_t t,
                            output logic [63:0] rdata);
        issue(addr, t, '0, 1'b0, rdata);
    endtask

    task automatic read_expect(input logic [63:0] addr, input bus_pkg::ls_type_t t,
                               input logic [63:0] exp, input bit is_claim, input string what);
        logic [63:0] unused;
        exp_value_q.push_back(exp);
        exp_claim_q.push_back(is_claim);
        exp_what_q.push_back(what);
        bus_read(addr, t, unused);
    endtask

    task automatic ram_store(input int at, input bus_pkg::ls_type_t t, input logic [63:0] wdata);
        ref_store(at, t, wdata);
        bus_write(soc_map_pkg::RAM_BASE + 64'(at), t, wdata);
    endtask

    task automatic ram_load_check(input int at, input bus_pkg::ls_type_t t);
        read_expect(soc_map_pkg::RAM_BASE + 64'(at), t, ref_load(at, t), 1'b0,
                    $sformatf("%s at offset %h", t.name(), at));
    endtask

    task automatic pulse_ext_irq();
        @(negedge clock_slow);
        ext_irq = 1'b1;
        @(negedge clock_slow);
        ext_irq = 1'b0;
        model_pending = 1'b1;
        @(negedge clock_slow);
    endtask

    task automatic check_irq_lines(input string when);
        check_flag(meip, ref_claim(model_pending, model_enable[0]) != 0, {"meip ", when});
        check_flag(seip, ref_claim(model_pending, model_enable[1]) != 0, {"seip ", when});
    endtask

    // compares each read result once its done flag has risen
    always @(negedge clock_slow) begin
        if (bus_read_done && !read_done_prev && exp_value_q.size() > 0) begin
            if (exp_claim_q[0])
                check_claim(bus_read_data, int'(exp_value_q[0]), exp_what_q[0]);
            else
                check_data(bus_read_data, exp_value_q[0], exp_what_q[0]);
            void'(exp_value_q.pop_front());
            void'(exp_claim_q.pop_front());
            void'(exp_what_q.pop_front());
        end
        read_done_prev = bus_read_done;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock_slow);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a bus access never completed", cycle_count);
        $display("Verification failed");
        $finish;
    end

    initial begin
        clock_slow      = 1'b0;
        KEY0            = 1'b0;
        bus_req         = '0;
        ext_irq         = 1'b0;
        read_done_prev  = 1'b1;
        model_pending   = 1'b0;
        model_enable[0] = 1'b0;
        model_enable[1] = 1'b0;
        repeat (5) @(negedge clock_slow);
        KEY0 = 1'b1;
        check_flag(bus_read_done, 1'b1, "bus_read_done after reset");
        check_flag(bus_write_done, 1'b1, "bus_write_done after reset");
        check_flag(mtip, 1'b0, "mtip after reset");
        check_irq_lines("after reset");

        for (int w = 0; w < FILL_WORDS; w++)
            ram_store(4 * w, bus_pkg::LS_W, {32'b0, fill_word(w)});

        // random store, then a random load somewhere in the RAM
        for (int n = 0; n < RAND_STORES; n++) begin
            ls   = bus_pkg::ls_type_t'(3'(take_bits(2)));
            off  = int'(take_bits(11)) & ~(access_bytes(ls) - 1);
            data = {take_bits(32), take_bits(32)};
            ram_store(off, ls, data);
            ls  = bus_pkg::ls_type_t'(3'(take_bits(3) % 7));
            off = int'(take_bits(11)) & ~(access_bytes(ls) - 1);
            ram_load_check(off, ls);
        end

        ram_store(32'h100, bus_pkg::LS_D, 64'hfedc_ba98_7654_3210);
        ram_load_check(32'h100, bus_pkg::LS_D);
        ram_load_check(32'h104, bus_pkg::LS_W);
        ram_load_check(32'h100, bus_pkg::LS_WU);
        // last doubleword of the array
        ram_store(32'h7f8, bus_pkg::LS_D, 64'h8765_4321_0fed_cba9);
        ram_load_check(32'h7f8, bus_pkg::LS_D);

        read_expect(soc_map_pkg::MTIMECMP_ADDR, bus_pkg::LS_D, soc_map_pkg::MTIMECMP_RESET,
                    1'b0, "mtimecmp after reset");
        bus_read(soc_map_pkg::MTIME_ADDR, bus_pkg::LS_D, mtime_first);
        repeat (20) @(negedge clock_slow);
        bus_read(soc_map_pkg::MTIME_ADDR, bus_pkg::LS_D, mtime_second);
        check_flag(mtime_second - mtime_first >= 64'd20, 1'b1, "mtime growth over 20 cycles");
        bus_write(soc_map_pkg::MTIMECMP_ADDR, bus_pkg::LS_D, 64'h0123_4567_89ab_cdef);
        read_expect(soc_map_pkg::MTIMECMP_ADDR, bus_pkg::LS_D, 64'h0123_4567_89ab_cdef,
                    1'b0, "mtimecmp readback");
        check_flag(mtip, 1'b0, "mtip with mtimecmp far ahead");
        bus_write(soc_map_pkg::MTIMECMP_ADDR, bus_pkg::LS_D, mtime_second);
        check_flag(mtip, 1'b1, "mtip with mtimecmp below mtime");

        bus_write(soc_map_pkg::PLIC_ENABLE, bus_pkg::LS_W, 64'h2);
        model_enable[0] = 1'b1;
        pulse_ext_irq();
        check_irq_lines("after ext_irq, context 0 enabled");
        read_expect(soc_map_pkg::PLIC_CLAIM, bus_pkg::LS_W,
                    64'(ref_claim(model_pending, model_enable[0])), 1'b1, "context 0 claim");
        model_pending = 1'b0;
        check_irq_lines("after context 0 claim");
        read_expect(soc_map_pkg::PLIC_CLAIM, bus_pkg::LS_W,
                    64'(ref_claim(model_pending, model_enable[0])), 1'b1, "second claim");

        bus_write(soc_map_pkg::PLIC_ENABLE + 64'h80, bus_pkg::LS_W, 64'h2);
        model_enable[1] = 1'b1;
        pulse_ext_irq();
        check_irq_lines("after ext_irq, both contexts enabled");
        read_expect(soc_map_pkg::PLIC_CLAIM + soc_map_pkg::PLIC_CTX_STRIDE, bus_pkg::LS_W,
                    64'(ref_claim(model_pending, model_enable[1])), 1'b1, "context 1 claim");
        model_pending = 1'b0;
        check_irq_lines("after context 1 claim");

        for (int id = 0; id < soc_map_pkg::PLIC_SOURCES; id++)
            bus_write(soc_map_pkg::PLIC_BASE + 64'(4 * id), bus_pkg::LS_W, 64'(id * 3 % 8));
        for (int id = 0; id < soc_map_pkg::PLIC_SOURCES; id++)
            read_expect(soc_map_pkg::PLIC_BASE + 64'(4 * id), bus_pkg::LS_W,
                        64'(id * 3 % 8), 1'b0, $sformatf("priority %0d", id));
        for (int c = 0; c < 2; c++) begin
            bus_write(soc_map_pkg::PLIC_ENABLE + 64'(c * 128), bus_pkg::LS_W,
                      64'(32'hc3a5_0f02 + c));
            bus_write(soc_map_pkg::PLIC_THRESHOLD + 64'(c) * soc_map_pkg::PLIC_CTX_STRIDE,
                      bus_pkg::LS_W, 64'(5 + c));
            read_expect(soc_map_pkg::PLIC_ENABLE + 64'(c * 128), bus_pkg::LS_W,
                        64'(32'hc3a5_0f02 + c), 1'b0, $sformatf("enable %0d", c));
            read_expect(soc_map_pkg::PLIC_THRESHOLD + 64'(c) * soc_map_pkg::PLIC_CTX_STRIDE,
                        bus_pkg::LS_W, 64'(5 + c), 1'b0, $sformatf("threshold %0d", c));
        end

        read_expect(64'h4000_0000, bus_pkg::LS_D, 64'h0, 1'b0, "unmapped read");
        bus_write(64'h4000_0000, bus_pkg::LS_D, '1);
        // just past the end of the RAM
        bus_write(soc_map_pkg::RAM_BASE + 64'h800, bus_pkg::LS_W, '1);
        for (int w = 0; w < FILL_WORDS; w++)
            ram_load_check(4 * w, bus_pkg::LS_WU);

        @(negedge clock_slow);
        if (exp_value_q.size() != 0) begin
            data_errors++;
            $display("%0d read results were never compared", exp_value_q.size());
        end
        $display("errors: data %0d, flag %0d, claim %0d, latency %0d",
                 data_errors, flag_errors, claim_errors, latency_errors);
        if (data_errors + flag_errors + claim_errors + latency_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== logic/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top (
    input  logic              clock_slow,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus_req,
    input  logic              ext_irq,
    output logic [63:0]       bus_read_data,
    output logic              bus_read_done,
    output logic              bus_write_done,
    output logic              mtip,
    output logic              meip,
    output logic              seip
);

    bus_pkg::slave_cmd_t cmd;
    logic [63:0]         ram_rdata;
    logic [63:0]         timer_rdata;
    logic [63:0]         plic_rdata;

    bus_access_fsm bus_access_fsm_inst (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .cmd            (cmd),
        .ram_rdata      (ram_rdata),
        .timer_rdata    (timer_rdata),
        .plic_rdata     (plic_rdata),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

    machine_timer machine_timer_inst (
        .clock_slow  (clock_slow),
        .KEY0        (KEY0),
        .cmd         (cmd),
        .wdata       (bus_req.write_data),
        .timer_rdata (timer_rdata),
        .mtip        (mtip)
    );

    // the core holds ls_type and write_data until done
    scratch_ram scratch_ram_inst (
        .clock_slow (clock_slow),
        .cmd        (cmd),
        .ls_type    (bus_req.ls_type),
        .wdata      (bus_req.write_data),
        .ram_rdata  (ram_rdata)
    );

    plic_regs plic_regs_inst (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .cmd        (cmd),
        .wdata      (bus_req.write_data),
        .ext_irq    (ext_irq),
        .plic_rdata (plic_rdata),
        .meip       (meip),
        .seip       (seip)
    );

endmodule

// ==== logic/plic_regs.sv ====
`timescale 1ns/1ps

module plic_regs (
    input  logic                clock_slow,
    input  logic                KEY0,
    input  bus_pkg::slave_cmd_t cmd,
    input  logic [63:0]         wdata,
    input  logic                ext_irq,
    output logic [63:0]         plic_rdata,
    output logic                meip,
    output logic                seip
);

    logic [2:0]  prio [soc_map_pkg::PLIC_SOURCES];
    logic [31:0] pending;
    logic [31:0] enable [2];
    logic [2:0]  threshold [2];
    logic        ext_irq_q;
    logic        sel;
    logic [63:0] addr;
    logic [31:0] prio_id;
    logic        prio_sel;
    logic [1:0]  claim_hit;
    logic [1:0]  claim_rd;

    function automatic logic [63:0] enable_addr(input int ctx);
        return soc_map_pkg::PLIC_ENABLE + 64'(ctx) * 64'h80;
    endfunction

    function automatic logic [63:0] threshold_addr(input int ctx);
        return soc_map_pkg::PLIC_THRESHOLD + 64'(ctx) * soc_map_pkg::PLIC_CTX_STRIDE;
    endfunction

    function automatic logic [63:0] claim_addr(input int ctx);
        return soc_map_pkg::PLIC_CLAIM + 64'(ctx) * soc_map_pkg::PLIC_CTX_STRIDE;
    endfunction

    assign sel      = cmd.region == soc_map_pkg::REGION_PLIC;
    assign addr     = soc_map_pkg::PLIC_BASE + {32'b0, cmd.offset};
    assign prio_id  = cmd.offset >> 2;
    assign prio_sel = addr < soc_map_pkg::PLIC_PENDING && prio_id < soc_map_pkg::PLIC_SOURCES;

    // no threshold or priority gating
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_hit[c] = pending[soc_map_pkg::EXT_IRQ_ID] &&
                           enable[c][soc_map_pkg::EXT_IRQ_ID];
            claim_rd[c]  = sel && cmd.rd && addr == claim_addr(c);
        end
    end

    assign meip = claim_hit[0];
    assign seip = claim_hit[1];

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            ext_irq_q <= 1'b0;
            pending   <= '0;
            for (int i = 0; i < soc_map_pkg::PLIC_SOURCES; i++)
                prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            ext_irq_q <= ext_irq;
            if (|claim_rd)
                pending[soc_map_pkg::EXT_IRQ_ID] <= 1'b0;
            // new edge wins over a claim in the same cycle
            if (ext_irq && !ext_irq_q)
                pending[soc_map_pkg::EXT_IRQ_ID] <= 1'b1;
            if (sel && cmd.wr) begin
                if (prio_sel)
                    prio[prio_id[2:0]] <= wdata[2:0];
                // claim writes fall through with no effect
                for (int c = 0; c < 2; c++) begin
                    if (addr == enable_addr(c))
                        enable[c] <= wdata[31:0];
                    if (addr == threshold_addr(c))
                        threshold[c] <= wdata[2:0];
                end
            end
        end
    end

    always_comb begin
        plic_rdata = '0;
        if (sel) begin
            if (prio_sel)
                plic_rdata = {61'b0, prio[prio_id[2:0]]};
            if (addr == soc_map_pkg::PLIC_PENDING)
                plic_rdata = {32'b0, pending};
            for (int c = 0; c < 2; c++) begin
                if (addr == enable_addr(c))
                    plic_rdata = {32'b0, enable[c]};
                if (addr == threshold_addr(c))
                    plic_rdata = {61'b0, threshold[c]};
                if (addr == claim_addr(c))
                    plic_rdata = claim_hit[c] ? 64'(soc_map_pkg::EXT_IRQ_ID) : 64'd0;
            end
        end
    end

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram (
    input  logic                clock_slow,
    input  bus_pkg::slave_cmd_t cmd,
    input  bus_pkg::ls_type_t   ls_type,
    input  logic [63:0]         wdata,
    output logic [63:0]         ram_rdata
);

    logic [31:0]                     mem [soc_map_pkg::RAM_WORDS];
    logic                            sel;
    logic [31:0]                     word_idx;
    logic [soc_map_pkg::RAM_AW-1:0]  word_addr;
    logic [3:0]                      lane_en;
    logic [31:0]                     lane_data;
    logic [31:0]                     rd_word;
    bus_pkg::ls_type_t               rd_type;

    assign sel       = cmd.region == soc_map_pkg::REGION_RAM;
    // upper half of a doubleword sits one word higher
    assign word_idx  = (cmd.offset >> 2) + 32'(cmd.word_half);
    assign word_addr = word_idx[soc_map_pkg::RAM_AW-1:0];

    // byte lanes with the data replicated across the word
    always_comb begin
        case (ls_type)
            bus_pkg::LS_B: begin
                lane_en   = 4'b0001 << cmd.offset[1:0];
                lane_data = {4{wdata[7:0]}};
            end
            bus_pkg::LS_H: begin
                lane_en   = 4'b0011 << cmd.offset[1:0];
                lane_data = {2{wdata[15:0]}};
            end
            bus_pkg::LS_D: begin
                lane_en   = 4'b1111;
                lane_data = cmd.word_half ? wdata[63:32] : wdata[31:0];
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge clock_slow) begin
        if (sel && cmd.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i])
                    mem[word_addr][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
        if (sel && cmd.rd) begin
            rd_word <= mem[word_addr] >> {cmd.offset[1:0], 3'b000};
            rd_type <= ls_type;
        end
    end

    always_comb begin
        case (rd_type)
            bus_pkg::LS_B:  ram_rdata = {{56{rd_word[7]}}, rd_word[7:0]};
            bus_pkg::LS_H:  ram_rdata = {{48{rd_word[15]}}, rd_word[15:0]};
            bus_pkg::LS_W:  ram_rdata = {{32{rd_word[31]}}, rd_word};
            bus_pkg::LS_BU: ram_rdata = {56'b0, rd_word[7:0]};
            bus_pkg::LS_HU: ram_rdata = {48'b0, rd_word[15:0]};
            // lwu, and either word of ld
            default:        ram_rdata = {32'b0, rd_word};
        endcase
    end

    // sd or ld at the last word would run past the array
    assert property (@(posedge clock_slow)
        (sel && (cmd.rd || cmd.wr)) |-> word_idx < soc_map_pkg::RAM_WORDS);

endmodule

// ==== logic/machine_timer.sv ====
`timescale 1ns/1ps

module machine_timer (
    input  logic                clock_slow,
    input  logic                KEY0,
    input  bus_pkg::slave_cmd_t cmd,
    input  logic [63:0]         wdata,
    output logic [63:0]         timer_rdata,
    output logic                mtip
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= soc_map_pkg::MTIMECMP_RESET;
        end else begin
            // free running at one tick per clock
            mtime <= mtime + 64'd1;
            if (cmd.wr && cmd.region == soc_map_pkg::REGION_MTIMECMP)
                mtimecmp <= wdata;
        end
    end

    always_comb begin
        case (cmd.region)
            soc_map_pkg::REGION_MTIME:    timer_rdata = mtime;
            soc_map_pkg::REGION_MTIMECMP: timer_rdata = mtimecmp;
            default:                      timer_rdata = '0;
        endcase
    end

    assign mtip = mtime >= mtimecmp;

endmodule

// ==== logic/bus_access_fsm.sv ====
`timescale 1ns/1ps

module bus_access_fsm (
    input  logic                clock_slow,
    input  logic                KEY0,
    input  bus_pkg::bus_req_t   bus_req,
    output bus_pkg::slave_cmd_t cmd,
    input  logic [63:0]         ram_rdata,
    input  logic [63:0]         timer_rdata,
    input  logic [63:0]         plic_rdata,
    output logic [63:0]         bus_read_data,
    output logic                bus_read_done,
    output logic                bus_write_done
);

    bus_pkg::access_state_t state;
    bus_pkg::ls_type_t      req_type;
    logic                   req_write;
    soc_map_pkg::region_t   req_region;
    logic [31:0]            req_offset;
    logic                   start;
    logic                   ram_sel;

    function automatic soc_map_pkg::region_t decode(input logic [63:0] addr);
        if (addr >= soc_map_pkg::RAM_BASE &&
            addr < soc_map_pkg::RAM_BASE + 64'(soc_map_pkg::RAM_WORDS * 4))
            return soc_map_pkg::REGION_RAM;
        if (addr == soc_map_pkg::MTIME_ADDR)
            return soc_map_pkg::REGION_MTIME;
        if (addr == soc_map_pkg::MTIMECMP_ADDR)
            return soc_map_pkg::REGION_MTIMECMP;
        // up to and including the claim word of context 1
        if (addr >= soc_map_pkg::PLIC_BASE &&
            addr <= soc_map_pkg::PLIC_CLAIM + soc_map_pkg::PLIC_CTX_STRIDE)
            return soc_map_pkg::REGION_PLIC;
        return soc_map_pkg::REGION_NONE;
    endfunction

    always_comb begin
        req_region = decode(bus_req.address);
        case (req_region)
            soc_map_pkg::REGION_RAM:
                req_offset = bus_req.address[31:0] - soc_map_pkg::RAM_BASE[31:0];
            soc_map_pkg::REGION_PLIC:
                req_offset = bus_req.address[31:0] - soc_map_pkg::PLIC_BASE[31:0];
            default:
                req_offset = '0;
        endcase
    end

    // busy strobes are dropped
    assign start   = (state == bus_pkg::ST_IDLE) && (bus_req.read_en || bus_req.write_en);
    assign ram_sel = cmd.region == soc_map_pkg::REGION_RAM;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            state          <= bus_pkg::ST_IDLE;
            cmd            <= '0;
            req_type       <= bus_pkg::LS_B;
            req_write      <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            // rd and wr are single-cycle pulses
            cmd.rd <= 1'b0;
            cmd.wr <= 1'b0;
            case (state)
                bus_pkg::ST_IDLE: begin
                    if (start) begin
                        req_type       <= bus_req.ls_type;
                        req_write      <= bus_req.write_en;
                        cmd.region     <= req_region;
                        cmd.offset     <= req_offset;
                        cmd.word_half  <= 1'b0;
                        cmd.rd         <= !bus_req.write_en;
                        cmd.wr         <= bus_req.write_en;
                        bus_read_done  <= bus_req.write_en;
                        bus_write_done <= !bus_req.write_en;
                        state          <= bus_pkg::ST_DECODE;
                    end
                end
                bus_pkg::ST_DECODE: begin
                    if (ram_sel && !req_write) begin
                        state <= bus_pkg::ST_RAM_LO;
                    end else if (ram_sel && req_type == bus_pkg::LS_D) begin
                        // sd sends the upper word next
                        cmd.wr        <= 1'b1;
                        cmd.word_half <= 1'b1;
                        state         <= bus_pkg::ST_RAM_HI;
                    end else begin
                        state <= bus_pkg::ST_DONE;
                    end
                end
                bus_pkg::ST_RAM_LO: begin
                    if (req_type == bus_pkg::LS_D) begin
                        cmd.rd        <= 1'b1;
                        cmd.word_half <= 1'b1;
                        state         <= bus_pkg::ST_RAM_HI;
                    end else begin
                        state <= bus_pkg::ST_DONE;
                    end
                end
                bus_pkg::ST_RAM_HI: state <= bus_pkg::ST_DONE;
                default: begin
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= bus_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // load result held while bus_read_done is high
    always_ff @(posedge clock_slow) begin
        if (!req_write) begin
            case (state)
                bus_pkg::ST_DECODE: begin
                    case (cmd.region)
                        soc_map_pkg::REGION_MTIME,
                        soc_map_pkg::REGION_MTIMECMP: bus_read_data <= timer_rdata;
                        soc_map_pkg::REGION_PLIC:     bus_read_data <= plic_rdata;
                        // unmapped reads complete with zero
                        soc_map_pkg::REGION_NONE:     bus_read_data <= '0;
                        default:                      bus_read_data <= bus_read_data;
                    endcase
                end
                // whole result, or low word of ld
                bus_pkg::ST_RAM_LO: bus_read_data <= ram_rdata;
                bus_pkg::ST_DONE: begin
                    if (ram_sel && req_type == bus_pkg::LS_D)
                        bus_read_data[63:32] <= ram_rdata[31:0];
                end
                default: bus_read_data <= bus_read_data;
            endcase
        end
    end

    // a done flag only falls on the edge after its strobe
    assert property (@(posedge clock_slow) disable iff (!KEY0)
        $fell(bus_read_done) |-> $past(bus_req.read_en));
    assert property (@(posedge clock_slow) disable iff (!KEY0)
        $fell(bus_write_done) |-> $past(bus_req.write_en));

    assert property (@(posedge clock_slow) disable iff (!KEY0)
        (ram_sel && (cmd.rd || cmd.wr)) |->
            (state == bus_pkg::ST_DECODE || state == bus_pkg::ST_RAM_HI));

endmodule

// ==== logic/bus_pkg.sv ====
package bus_pkg;

    // encoding taken from the funct3 field of loads and stores
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECODE,
        ST_RAM_LO,
        ST_RAM_HI,
        ST_DONE
    } access_state_t;

    // request as driven by the CPU core
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        ls_type_t    ls_type;
        logic        read_en;
        logic        write_en;
    } bus_req_t;

    // registered command seen by every slave
    typedef struct packed {
        soc_map_pkg::region_t region;
        logic [31:0]          offset;
        logic                 word_half;
        logic                 rd;
        logic                 wr;
    } slave_cmd_t;

endpackage

// ==== logic/soc_map_pkg.sv ====
package soc_map_pkg;

    // on-chip RAM of 2 KB in 32-bit words
    localparam logic [63:0] RAM_BASE  = 64'h8000_0000;
    localparam int          RAM_WORDS = 512;
    localparam int          RAM_AW    = 9;

    // machine timer
    localparam logic [63:0] MTIMECMP_ADDR  = 64'h0200_4000;
    localparam logic [63:0] MTIME_ADDR     = 64'h0200_BFF8;
    localparam logic [63:0] MTIMECMP_RESET = 64'h8000_0000;

    // PLIC priority of source id sits at base + 4 * id
    localparam logic [63:0] PLIC_BASE    = 64'h0C00_0000;
    localparam int          PLIC_SOURCES = 6;
    localparam logic [63:0] PLIC_PENDING = 64'h0C00_1000;
    // context 1 enable word is 0x80 above context 0
    localparam logic [63:0] PLIC_ENABLE  = 64'h0C00_2000;

    localparam logic [63:0] PLIC_THRESHOLD  = 64'h0C20_0000;
    localparam logic [63:0] PLIC_CLAIM      = 64'h0C20_0004;
    // threshold and claim of context 1
    localparam logic [63:0] PLIC_CTX_STRIDE = 64'h1000;

    // only source wired to the PLIC
    localparam int EXT_IRQ_ID = 1;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_MTIME,
        REGION_MTIMECMP,
        REGION_PLIC
    } region_t;

endpackage
